// ==== verilog/riscv_csr_pkg.sv ====
package riscv_csr_pkg;

  // 12-bit csr address space
  typedef logic [11:0] csr_addr_t;

  // machine information registers, all read only
  localparam csr_addr_t csr_mvendorid     = 12'hF11;
  localparam csr_addr_t csr_marchid       = 12'hF12;
  localparam csr_addr_t csr_mimpid        = 12'hF13;
  localparam csr_addr_t csr_mhartid       = 12'hF14;
  localparam csr_addr_t csr_mconfigptr    = 12'hF15;

  // trap setup
  localparam csr_addr_t csr_mstatus       = 12'h300;
  localparam csr_addr_t csr_misa          = 12'h301;
  localparam csr_addr_t csr_mie           = 12'h304;
  localparam csr_addr_t csr_mtvec         = 12'h305;
  localparam csr_addr_t csr_mcountinhibit = 12'h320;

  // trap handling
  localparam csr_addr_t csr_mscratch      = 12'h340;
  localparam csr_addr_t csr_mepc          = 12'h341;
  localparam csr_addr_t csr_mcause        = 12'h342;
  localparam csr_addr_t csr_mip           = 12'h344;

  // performance counters
  localparam csr_addr_t csr_mcycle        = 12'hB00;
  localparam csr_addr_t csr_minstret      = 12'hB02;

  // op codes from the decoder, unlisted codes do nothing
  typedef enum logic [2:0] {
    csr_write = 3'b001,
    csr_set   = 3'b010,
    csr_clear = 3'b011,
    csr_read  = 3'b101,
    csr_mret  = 3'b111
  } csr_op_t;

  typedef enum logic [1:0] {
    priv_u = 2'b00,
    priv_s = 2'b01,
    priv_m = 2'b11
  } priv_t;

  typedef logic [3:0] cause_t;

  // interrupt codes, also the mie / mip bit positions
  localparam cause_t irq_s_timer = 4'd5;
  localparam cause_t irq_m_timer = 4'd7;
  localparam cause_t irq_s_ext   = 4'd9;
  localparam cause_t irq_m_ext   = 4'd11;

  // synchronous exception codes
  localparam cause_t exc_inst_misaligned  = 4'd0;
  localparam cause_t exc_illegal          = 4'd2;
  localparam cause_t exc_load_misaligned  = 4'd4;
  localparam cause_t exc_store_misaligned = 4'd6;
  localparam cause_t exc_ecall_m          = 4'd11;

  // mstatus fields kept here
  localparam int mstatus_mie_bit  = 3;
  localparam int mstatus_mpie_bit = 7;
  localparam int mstatus_mpp_lo   = 11; // 2 bits
  localparam int mstatus_uxl_lo   = 32; // sxl sits right above

  // misa: A C I M S U, mxl = 2 for rv64
  localparam logic [63:0] misa_value = (64'd1 << 0)
                                     | (64'd1 << 2)
                                     | (64'd1 << 8)
                                     | (64'd1 << 12)
                                     | (64'd1 << 18)
                                     | (64'd1 << 20)
                                     | (64'd2 << 62);

endpackage

// ==== verilog/riscv_counter.sv ====
`timescale 1ns/100ps

module riscv_counter #(
  parameter int WIDTH = 64
) (
  input  logic             i_riscv_csr_clk,
  input  logic             i_riscv_csr_rst,
  input  logic             i_write_en,  // csr write loads a value
  input  logic             i_incr_en,
  input  logic [WIDTH-1:0] i_value,
  output logic [WIDTH-1:0] o_value
);

  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
      o_value <= '0;
    else if (i_write_en)
      o_value <= i_value;          // load wins over count
    else if (i_incr_en)
      o_value <= o_value + 1'b1;   // wraps silently
  end

endmodule

// ==== verilog/riscv_csr_decode.sv ====
`timescale 1ns/100ps

module riscv_csr_decode #(
  parameter int MXLEN = 64
) (
  input  riscv_csr_pkg::csr_op_t   i_riscv_csr_op,
  input  riscv_csr_pkg::csr_addr_t i_riscv_csr_address,
  input  logic [MXLEN-1:0]         i_riscv_csr_wdata,
  input  logic                     i_riscv_csr_globstall,
  input  logic [MXLEN-1:0]         i_rdata_raw,    // current csr value, for set / clear
  input  logic                     i_unknown_addr,
  input  riscv_csr_pkg::priv_t     i_priv,
  output logic                     o_csr_we,
  output logic                     o_csr_read,
  output logic                     o_mret,
  output logic [MXLEN-1:0]         o_wdata_op,
  output logic                     o_illegal_csr
);

  import riscv_csr_pkg::*;

  logic wr_op;        // op wants to write, before any gating
  logic illegal_priv;
  logic illegal_ro;

  // op decode and read-modify-write data
  always_comb
  begin
    wr_op      = 1'b0;
    o_csr_read = 1'b0;
    o_mret     = 1'b0;
    o_wdata_op = i_riscv_csr_wdata;
    case (i_riscv_csr_op)
      csr_write:
      begin
        wr_op      = 1'b1;
        o_csr_read = 1'b1;
      end
      csr_set:
      begin
        wr_op      = 1'b1;
        o_csr_read = 1'b1;
        o_wdata_op = i_rdata_raw | i_riscv_csr_wdata;  // old or data
      end
      csr_clear:
      begin
        wr_op      = 1'b1;
        o_csr_read = 1'b1;
        o_wdata_op = i_rdata_raw & ~i_riscv_csr_wdata; // old and not data
      end
      csr_read:
        o_csr_read = 1'b1;
      csr_mret:
        o_mret = 1'b1; // no csr access
      default:
        wr_op = 1'b0;  // anything else is a no-op
    endcase
  end

  // address bits 9:8 give the lowest privilege allowed
  assign illegal_priv = i_riscv_csr_address[9:8] > i_priv;
  // 11:10 == 11 is the read-only space
  assign illegal_ro   = (i_riscv_csr_address[11:10] == 2'b11) && wr_op;

  // only a real access can be illegal
  assign o_illegal_csr = o_csr_read && (illegal_priv || illegal_ro || i_unknown_addr);

  // a stalled or illegal access never writes
  assign o_csr_we = wr_op && !o_illegal_csr && !i_riscv_csr_globstall;

endmodule

// ==== verilog/riscv_csr_trap.sv ====
`timescale 1ns/100ps

module riscv_csr_trap #(
  parameter int MXLEN        = 64,
  parameter bit SUPPORT_USER = 1'b1
) (
  input  logic                     i_riscv_csr_clk,
  input  logic                     i_riscv_csr_rst,
  input  logic                     i_riscv_csr_globstall,
  input  logic                     i_csr_we,
  input  riscv_csr_pkg::csr_addr_t i_riscv_csr_address,
  input  logic [MXLEN-1:0]         i_wdata_op,
  input  logic                     i_mret,
  input  logic                     i_illegal_csr,
  input  logic                     i_riscv_csr_illegal_inst,
  input  logic                     i_riscv_csr_ecall_m,
  input  logic                     i_riscv_csr_inst_addr_misaligned,
  input  logic                     i_riscv_csr_load_addr_misaligned,
  input  logic                     i_riscv_csr_store_addr_misaligned,
  input  logic                     i_irq_m_ext_pending,   // already masked by mie / MIE
  input  logic                     i_irq_m_timer_pending,
  input  logic [MXLEN-1:0]         i_riscv_csr_pc,
  output logic                     o_gototrap,
  output logic                     o_mstatus_mie,
  output logic                     o_mstatus_mpie,
  output riscv_csr_pkg::priv_t     o_mstatus_mpp,
  output logic [MXLEN-1:0]         o_mepc,
  output logic [MXLEN-1:0]         o_mcause,
  output riscv_csr_pkg::priv_t     o_priv
);

  import riscv_csr_pkg::*;

  logic   illegal_any;   // decoder or csr access
  logic   exception;
  logic   cause_irq;     // next mcause interrupt flag
  cause_t cause_code;
  logic   mcause_irq_q;
  cause_t mcause_code_q;

  assign illegal_any = i_illegal_csr || i_riscv_csr_illegal_inst;
  assign exception   = illegal_any || i_riscv_csr_ecall_m
                    || i_riscv_csr_inst_addr_misaligned
                    || i_riscv_csr_load_addr_misaligned
                    || i_riscv_csr_store_addr_misaligned;

  assign o_gototrap = exception || i_irq_m_ext_pending || i_irq_m_timer_pending;

  // fixed priority, interrupts first
  always_comb
  begin
    cause_irq  = 1'b0;
    cause_code = exc_store_misaligned;
    if (i_irq_m_ext_pending)
    begin
      cause_irq  = 1'b1;
      cause_code = irq_m_ext;
    end
    else if (i_irq_m_timer_pending)
    begin
      cause_irq  = 1'b1;
      cause_code = irq_m_timer;
    end
    else if (illegal_any)
      cause_code = exc_illegal;
    else if (i_riscv_csr_inst_addr_misaligned)
      cause_code = exc_inst_misaligned;
    else if (i_riscv_csr_ecall_m)
      cause_code = exc_ecall_m;
    else if (i_riscv_csr_load_addr_misaligned)
      cause_code = exc_load_misaligned;
  end

  // mstatus and privilege, trap beats mret beats a csr write
  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
    begin
      o_mstatus_mie  <= 1'b0;
      o_mstatus_mpie <= 1'b0;
      o_mstatus_mpp  <= priv_u;
      o_priv         <= priv_m; // come out of reset in machine mode
    end
    else if (!i_riscv_csr_globstall)
    begin
      if (o_gototrap)
      begin
        o_mstatus_mpie <= o_mstatus_mie;
        o_mstatus_mie  <= 1'b0;
        o_mstatus_mpp  <= priv_m;
        o_priv         <= priv_m;
      end
      else if (i_mret)
      begin
        o_priv         <= o_mstatus_mpp;
        o_mstatus_mie  <= o_mstatus_mpie;
        o_mstatus_mpie <= 1'b1;
        o_mstatus_mpp  <= SUPPORT_USER ? priv_u : priv_m; // least privileged mode
      end
      else if (i_csr_we && i_riscv_csr_address == csr_mstatus)
      begin
        o_mstatus_mie  <= i_wdata_op[mstatus_mie_bit];
        o_mstatus_mpie <= i_wdata_op[mstatus_mpie_bit];
        o_mstatus_mpp  <= priv_t'(i_wdata_op[mstatus_mpp_lo +: 2]);
      end
    end
  end

  // mepc and mcause
  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
    begin
      o_mepc        <= '0;
      mcause_irq_q  <= 1'b0;
      mcause_code_q <= '0;
    end
    else if (!i_riscv_csr_globstall)
    begin
      if (o_gototrap)
      begin
        o_mepc        <= i_riscv_csr_pc; // pc of the trapping instruction
        mcause_irq_q  <= cause_irq;
        mcause_code_q <= cause_code;
      end
      else if (i_csr_we && i_riscv_csr_address == csr_mepc)
        o_mepc <= {i_wdata_op[MXLEN-1:1], 1'b0}; // bit 0 always zero
      else if (i_csr_we && i_riscv_csr_address == csr_mcause)
      begin
        mcause_irq_q  <= i_wdata_op[MXLEN-1];
        mcause_code_q <= i_wdata_op[3:0];
      end
    end
  end

  assign o_mcause = {mcause_irq_q, {(MXLEN-5){1'b0}}, mcause_code_q};

endmodule

// ==== verilog/riscv_csr_regs.sv ====
`timescale 1ns/100ps

module riscv_csr_regs #(
  parameter int MXLEN        = 64,
  parameter bit SUPPORT_USER = 1'b1
) (
  input  logic                     i_riscv_csr_clk,
  input  logic                     i_riscv_csr_rst,
  input  logic                     i_csr_we,
  input  logic                     i_csr_read,
  input  logic                     i_gototrap,
  input  riscv_csr_pkg::csr_addr_t i_riscv_csr_address,
  input  logic [MXLEN-1:0]         i_wdata_op,
  input  logic                     i_riscv_csr_instret,
  input  logic                     i_mstatus_mie,
  input  logic                     i_mstatus_mpie,
  input  riscv_csr_pkg::priv_t     i_mstatus_mpp,
  input  logic [MXLEN-1:0]         i_mepc,
  input  logic [MXLEN-1:0]         i_mcause,
  output logic [MXLEN-1:0]         o_rdata,
  output logic                     o_unknown_addr,
  output logic [MXLEN-1:0]         o_mtvec,
  output logic                     o_irq_m_ext_pending,
  output logic                     o_irq_m_timer_pending
);

  import riscv_csr_pkg::*;

  // implemented interrupt bits in mie / mip
  localparam logic [11:0] irq_mask = (12'd1 << irq_s_timer) | (12'd1 << irq_m_timer)
                                   | (12'd1 << irq_s_ext) | (12'd1 << irq_m_ext);

  logic             we;           // write enable, dropped on a trap
  logic [11:0]      mie_q;
  logic [11:0]      mip_q;        // software written only
  logic [MXLEN-1:0] mscratch_q;
  logic [2:0]       inhibit_q;    // bit 1 stays zero
  logic [MXLEN-1:0] mcycle;
  logic [MXLEN-1:0] minstret;

  assign we = i_csr_we && !i_gototrap;

  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
    begin
      o_mtvec   <= MXLEN'(64'h003F_FFFC); // direct mode
      mie_q     <= '0;
      mip_q     <= '0;
      inhibit_q <= '0;
    end
    else if (we)
    begin
      case (i_riscv_csr_address)
        csr_mtvec:
          if (i_wdata_op[0])
            o_mtvec <= {i_wdata_op[MXLEN-1:8], 6'b0, 2'b01}; // vectored base is 256B aligned
          else
            o_mtvec <= {i_wdata_op[MXLEN-1:2], 2'b00};
        csr_mie:           mie_q     <= i_wdata_op[11:0] & irq_mask;
        csr_mip:           mip_q     <= i_wdata_op[11:0] & irq_mask;
        csr_mcountinhibit: inhibit_q <= {i_wdata_op[2], 1'b0, i_wdata_op[0]};
        default:           inhibit_q <= inhibit_q;
      endcase
    end
  end

  // plain scratch word
  always_ff @(posedge i_riscv_csr_clk)
  begin
    if (we && i_riscv_csr_address == csr_mscratch)
      mscratch_q <= i_wdata_op;
  end

  // enabled and pending machine interrupts
  assign o_irq_m_ext_pending   = i_mstatus_mie && mie_q[irq_m_ext] && mip_q[irq_m_ext];
  assign o_irq_m_timer_pending = i_mstatus_mie && mie_q[irq_m_timer] && mip_q[irq_m_timer];

  riscv_counter #(
    .WIDTH (MXLEN)
  ) u_mcycle (
    .i_riscv_csr_clk (i_riscv_csr_clk),
    .i_riscv_csr_rst (i_riscv_csr_rst),
    .i_write_en      (we && i_riscv_csr_address == csr_mcycle),
    .i_incr_en       (!inhibit_q[0]),
    .i_value         (i_wdata_op),
    .o_value         (mcycle)
  );

  riscv_counter #(
    .WIDTH (MXLEN)
  ) u_minstret (
    .i_riscv_csr_clk (i_riscv_csr_clk),
    .i_riscv_csr_rst (i_riscv_csr_rst),
    .i_write_en      (we && i_riscv_csr_address == csr_minstret),
    .i_incr_en       (i_riscv_csr_instret && !inhibit_q[2]),
    .i_value         (i_wdata_op),
    .o_value         (minstret)
  );

  // read mux, anything not listed is unknown
  always_comb
  begin
    o_rdata        = '0;
    o_unknown_addr = 1'b0;
    if (i_csr_read)
    begin
      case (i_riscv_csr_address)
        csr_mvendorid, csr_marchid, csr_mimpid, csr_mhartid, csr_mconfigptr:
          o_rdata = '0; // id registers read zero
        csr_misa:
          o_rdata = misa_value[MXLEN-1:0];
        csr_mstatus:
        begin
          o_rdata[mstatus_mie_bit]       = i_mstatus_mie;
          o_rdata[mstatus_mpie_bit]      = i_mstatus_mpie;
          o_rdata[mstatus_mpp_lo +: 2]   = i_mstatus_mpp;
          o_rdata[mstatus_uxl_lo +: 2]   = SUPPORT_USER ? 2'b10 : 2'b00;
          o_rdata[mstatus_uxl_lo+2 +: 2] = 2'b10; // sxl fixed at 64 bit
        end
        csr_mie:           o_rdata[11:0] = mie_q;
        csr_mip:           o_rdata[11:0] = mip_q;
        csr_mtvec:         o_rdata       = o_mtvec;
        csr_mscratch:      o_rdata       = mscratch_q;
        csr_mepc:          o_rdata       = i_mepc;
        csr_mcause:        o_rdata       = i_mcause;
        csr_mcountinhibit: o_rdata[2:0]  = inhibit_q;
        csr_mcycle:        o_rdata       = mcycle;
        csr_minstret:      o_rdata       = minstret;
        default:           o_unknown_addr = 1'b1;
      endcase
    end
  end

endmodule

// ==== verilog/riscv_csrfile.sv ====
`timescale 1ns/100ps

module riscv_csrfile #(
  parameter int MXLEN        = 64,
  parameter bit SUPPORT_USER = 1'b1
) (
  input  logic                     i_riscv_csr_clk,
  input  logic                     i_riscv_csr_rst,
  input  riscv_csr_pkg::csr_addr_t i_riscv_csr_address,
  input  riscv_csr_pkg::csr_op_t   i_riscv_csr_op,
  input  logic [MXLEN-1:0]         i_riscv_csr_wdata,
  input  logic                     i_riscv_csr_globstall,  // freezes all state
  input  logic [MXLEN-1:0]         i_riscv_csr_pc,
  input  logic                     i_riscv_csr_instret,
  input  logic                     i_riscv_csr_illegal_inst,
  input  logic                     i_riscv_csr_ecall_m,
  input  logic                     i_riscv_csr_inst_addr_misaligned,
  input  logic                     i_riscv_csr_load_addr_misaligned,
  input  logic                     i_riscv_csr_store_addr_misaligned,
  output logic [MXLEN-1:0]         o_riscv_csr_rdata,
  output logic [MXLEN-1:0]         o_riscv_csr_return_address, // mepc
  output logic [MXLEN-1:0]         o_riscv_csr_trap_address,   // mtvec
  output logic                     o_riscv_csr_gototrap,
  output logic                     o_riscv_csr_returnfromtrap,
  output riscv_csr_pkg::priv_t     o_riscv_csr_privlvl
);

  import riscv_csr_pkg::*;

  logic             csr_we;
  logic             csr_read;
  logic             mret;
  logic             illegal_csr;
  logic             unknown_addr;
  logic             irq_m_ext_pending;
  logic             irq_m_timer_pending;
  logic             mstatus_mie;
  logic             mstatus_mpie;
  priv_t            mstatus_mpp;
  priv_t            priv;
  logic [MXLEN-1:0] wdata_op;       // after set / clear
  logic [MXLEN-1:0] mcause;

  assign o_riscv_csr_returnfromtrap = mret;
  assign o_riscv_csr_privlvl        = priv;

  riscv_csr_decode #(
    .MXLEN (MXLEN)
  ) u_decode (
    .i_riscv_csr_op        (i_riscv_csr_op),
    .i_riscv_csr_address   (i_riscv_csr_address),
    .i_riscv_csr_wdata     (i_riscv_csr_wdata),
    .i_riscv_csr_globstall (i_riscv_csr_globstall),
    .i_rdata_raw           (o_riscv_csr_rdata),
    .i_unknown_addr        (unknown_addr),
    .i_priv                (priv),
    .o_csr_we              (csr_we),
    .o_csr_read            (csr_read),
    .o_mret                (mret),
    .o_wdata_op            (wdata_op),
    .o_illegal_csr         (illegal_csr)
  );

  riscv_csr_trap #(
    .MXLEN        (MXLEN),
    .SUPPORT_USER (SUPPORT_USER)
  ) u_trap (
    .i_riscv_csr_clk                   (i_riscv_csr_clk),
    .i_riscv_csr_rst                   (i_riscv_csr_rst),
    .i_riscv_csr_globstall             (i_riscv_csr_globstall),
    .i_csr_we                          (csr_we),
    .i_riscv_csr_address               (i_riscv_csr_address),
    .i_wdata_op                        (wdata_op),
    .i_mret                            (mret),
    .i_illegal_csr                     (illegal_csr),
    .i_riscv_csr_illegal_inst          (i_riscv_csr_illegal_inst),
    .i_riscv_csr_ecall_m               (i_riscv_csr_ecall_m),
    .i_riscv_csr_inst_addr_misaligned  (i_riscv_csr_inst_addr_misaligned),
    .i_riscv_csr_load_addr_misaligned  (i_riscv_csr_load_addr_misaligned),
    .i_riscv_csr_store_addr_misaligned (i_riscv_csr_store_addr_misaligned),
    .i_irq_m_ext_pending               (irq_m_ext_pending),
    .i_irq_m_timer_pending             (irq_m_timer_pending),
    .i_riscv_csr_pc                    (i_riscv_csr_pc),
    .o_gototrap                        (o_riscv_csr_gototrap),
    .o_mstatus_mie                     (mstatus_mie),
    .o_mstatus_mpie                    (mstatus_mpie),
    .o_mstatus_mpp                     (mstatus_mpp),
    .o_mepc                            (o_riscv_csr_return_address),
    .o_mcause                          (mcause),
    .o_priv                            (priv)
  );

  riscv_csr_regs #(
    .MXLEN        (MXLEN),
    .SUPPORT_USER (SUPPORT_USER)
  ) u_regs (
    .i_riscv_csr_clk       (i_riscv_csr_clk),
    .i_riscv_csr_rst       (i_riscv_csr_rst),
    .i_csr_we              (csr_we),
    .i_csr_read            (csr_read),
    .i_gototrap            (o_riscv_csr_gototrap),
    .i_riscv_csr_address   (i_riscv_csr_address),
    .i_wdata_op            (wdata_op),
    .i_riscv_csr_instret   (i_riscv_csr_instret),
    .i_mstatus_mie         (mstatus_mie),
    .i_mstatus_mpie        (mstatus_mpie),
    .i_mstatus_mpp         (mstatus_mpp),
    .i_mepc                (o_riscv_csr_return_address),
    .i_mcause              (mcause),
    .o_rdata               (o_riscv_csr_rdata),
    .o_unknown_addr        (unknown_addr),
    .o_mtvec               (o_riscv_csr_trap_address),
    .o_irq_m_ext_pending   (irq_m_ext_pending),
    .o_irq_m_timer_pending (irq_m_timer_pending)
  );

endmodule

// ==== test/riscv_csrfile_tb.sv ====
`timescale 1ns/100ps

module riscv_csrfile_tb;

  import riscv_csr_pkg::*;

  localparam int MXLEN      = 64;
  localparam int clk_period = 8;
  localparam int rst_cycles = 10;

  // exception strobe bits in a table row
  localparam int ex_illegal = 0;
  localparam int ex_ecall   = 1;
  localparam int ex_inst    = 2;
  localparam int ex_load    = 3;
  localparam int ex_store   = 4;

  localparam csr_op_t op_nop = csr_op_t'(3'b000); // unlisted code, does nothing

  // A C I M S U plus mxl = 2
  localparam logic [MXLEN-1:0] misa_exp    = 64'h8000_0000_0014_1105;
  localparam logic [MXLEN-1:0] mstatus_rst = 64'h0000_000A_0000_0000; // uxl = sxl = 2
  localparam logic [MXLEN-1:0] mpie_mpp_m  = 64'h0000_0000_0000_1880; // mpie plus mpp = m
  localparam logic [MXLEN-1:0] mpp_m       = 64'h0000_0000_0000_1800;

  // one row of the stimulus table
  typedef struct packed {
    csr_op_t          op;
    csr_addr_t        addr;
    logic [MXLEN-1:0] wdata;
    logic [4:0]       exc;
    logic             stall;
    logic             instret;
    logic [MXLEN-1:0] pc;
    logic             chk_rd;     // old value not always known
    logic [MXLEN-1:0] exp_rd;
    logic             exp_trap;
    logic             exp_ret;
    priv_t            exp_priv;
  } step_t;

  logic             clk;
  logic             rst;
  csr_addr_t        address;
  csr_op_t          op;
  logic [MXLEN-1:0] wdata;
  logic             globstall;
  logic [MXLEN-1:0] pc;
  logic             instret;
  logic [4:0]       exc;          // strobes, see ex_* positions
  logic [MXLEN-1:0] rdata;
  logic [MXLEN-1:0] return_address;
  logic [MXLEN-1:0] trap_address;
  logic             gototrap;
  logic             returnfromtrap;
  priv_t            privlvl;

  step_t steps[$];
  string names[$];
  bit    table_ready;
  int    err_count;
  int    fail_steps;

  riscv_csrfile #(
    .MXLEN        (MXLEN),
    .SUPPORT_USER (1'b1)
  ) i_riscv_csrfile (
    .i_riscv_csr_clk                   (clk),
    .i_riscv_csr_rst                   (rst),
    .i_riscv_csr_address               (address),
    .i_riscv_csr_op                    (op),
    .i_riscv_csr_wdata                 (wdata),
    .i_riscv_csr_globstall             (globstall),
    .i_riscv_csr_pc                    (pc),
    .i_riscv_csr_instret               (instret),
    .i_riscv_csr_illegal_inst          (exc[ex_illegal]),
    .i_riscv_csr_ecall_m               (exc[ex_ecall]),
    .i_riscv_csr_inst_addr_misaligned  (exc[ex_inst]),
    .i_riscv_csr_load_addr_misaligned  (exc[ex_load]),
    .i_riscv_csr_store_addr_misaligned (exc[ex_store]),
    .o_riscv_csr_rdata                 (rdata),
    .o_riscv_csr_return_address        (return_address),
    .o_riscv_csr_trap_address          (trap_address),
    .o_riscv_csr_gototrap              (gototrap),
    .o_riscv_csr_returnfromtrap        (returnfromtrap),
    .o_riscv_csr_privlvl               (privlvl)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period/2) clk = ~clk;
  end

  function automatic logic [MXLEN-1:0] rand_word();
    return {$urandom, $urandom};
  endfunction

  // rarely used columns have defaults
  task automatic add_step(input string name, input csr_op_t s_op, input csr_addr_t s_addr,
                          input logic [MXLEN-1:0] s_wdata, input logic s_chk,
                          input logic [MXLEN-1:0] s_exp, input logic [4:0] s_exc = '0,
                          input logic s_stall = 1'b0, input logic s_instret = 1'b0,
                          input logic [MXLEN-1:0] s_pc = '0, input logic s_trap = 1'b0,
                          input logic s_ret = 1'b0, input priv_t s_priv = priv_m);
    step_t s;
    s = '{s_op, s_addr, s_wdata, s_exc, s_stall, s_instret, s_pc, s_chk, s_exp,
          s_trap, s_ret, s_priv};
    steps.push_back(s);
    names.push_back(name);
  endtask

  task automatic check_word(input string name, input string what,
                            input logic [MXLEN-1:0] exp, input logic [MXLEN-1:0] act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s %s expected %h actual %h", name, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input string what,
                           input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s %s expected %b actual %b", name, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_priv(input string name, input priv_t exp, input priv_t act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s privlvl expected %b actual %b", name, exp, act);
      err_count++;
    end
  endtask

  task automatic build_table();
    logic [MXLEN-1:0] val_a;
    logic [MXLEN-1:0] val_b;
    logic [MXLEN-1:0] val_c;
    logic [MXLEN-1:0] val_d;
    logic [MXLEN-1:0] val_e;
    logic [MXLEN-1:0] vec_val;
    logic [MXLEN-1:0] pc_a;
    logic [MXLEN-1:0] pc_b;
    logic [MXLEN-1:0] pc_c;
    logic [MXLEN-1:0] set_val;
    logic [MXLEN-1:0] clr_val;
    val_a   = rand_word();
    val_b   = rand_word();
    val_c   = rand_word();
    val_d   = rand_word() | 64'h1;     // odd, so bit 0 must get dropped
    val_e   = rand_word();
    vec_val = (rand_word() & ~64'h3) | 64'h1; // vectored mode
    pc_a    = rand_word() & ~64'h3;
    pc_b    = rand_word() & ~64'h3;
    pc_c    = rand_word() & ~64'h3;
    set_val = val_a | val_b;
    clr_val = set_val & ~val_c;
    // reset values and constants
    add_step("misa_reset",     csr_read,  csr_misa,     '0,    1'b1, misa_exp);
    add_step("mtvec_reset",    csr_read,  csr_mtvec,    '0,    1'b1, 64'h003F_FFFC);
    add_step("mstatus_reset",  csr_read,  csr_mstatus,  '0,    1'b1, mstatus_rst);
    add_step("mepc_reset",     csr_read,  csr_mepc,     '0,    1'b1, '0);
    // write, set, clear, stalled write
    add_step("mscratch_write", csr_write, csr_mscratch, val_a, 1'b0, '0);
    add_step("mscratch_read",  csr_read,  csr_mscratch, '0,    1'b1, val_a);
    add_step("mscratch_set",   csr_set,   csr_mscratch, val_b, 1'b1, val_a);
    add_step("set_read",       csr_read,  csr_mscratch, '0,    1'b1, set_val);
    add_step("mscratch_clear", csr_clear, csr_mscratch, val_c, 1'b1, set_val);
    add_step("clear_read",     csr_read,  csr_mscratch, '0,    1'b1, clr_val);
    add_step("mepc_write",     csr_write, csr_mepc,     val_d, 1'b1, '0);
    add_step("mepc_read",      csr_read,  csr_mepc,     '0,    1'b1, val_d & ~64'h1);
    add_step("stall_write",    csr_write, csr_mscratch, val_e, 1'b1, clr_val, .s_stall(1'b1));
    add_step("stall_read",     csr_read,  csr_mscratch, '0,    1'b1, clr_val);
    // vectored mtvec drops base bits 7:2
    add_step("mtvec_write",    csr_write, csr_mtvec,    vec_val, 1'b1, 64'h003F_FFFC);
    add_step("mtvec_read",     csr_read,  csr_mtvec,    '0,    1'b1, vec_val & ~64'hFC);
    // ecall trap with MIE set beforehand
    add_step("mie_on",         csr_write, csr_mstatus,  64'h8, 1'b1, mstatus_rst);
    add_step("ecall",          op_nop,    csr_mstatus,  '0,    1'b1, '0,
             .s_exc(5'b1 << ex_ecall), .s_pc(pc_a), .s_trap(1'b1));
    add_step("ecall_mepc",     csr_read,  csr_mepc,     '0,    1'b1, pc_a);
    add_step("ecall_mcause",   csr_read,  csr_mcause,   '0,    1'b1, 64'd11);
    add_step("ecall_mstatus",  csr_read,  csr_mstatus,  '0,    1'b1, mstatus_rst | mpie_mpp_m);
    // illegal beats load misaligned
    add_step("illegal_load",   op_nop,    csr_mstatus,  '0,    1'b1, '0,
             .s_exc((5'b1 << ex_illegal) | (5'b1 << ex_load)), .s_pc(pc_b), .s_trap(1'b1));
    add_step("illegal_mcause", csr_read,  csr_mcause,   '0,    1'b1, 64'd2);
    // machine timer interrupt
    add_step("timer_mie",      csr_write, csr_mie,      64'h80,   1'b1, '0);
    add_step("timer_mstatus",  csr_write, csr_mstatus,  64'h1808, 1'b1, mstatus_rst | mpp_m);
    add_step("timer_mip",      csr_write, csr_mip,      64'h80,   1'b1, '0);
    add_step("timer_trap",     op_nop,    csr_mstatus,  '0,    1'b1, '0,
             .s_pc(pc_c), .s_trap(1'b1));
    add_step("timer_mcause",   csr_read,  csr_mcause,   '0,    1'b1, 64'h8000_0000_0000_0007);
    add_step("timer_mepc",     csr_read,  csr_mepc,     '0,    1'b1, pc_c);
    add_step("mip_clear",      csr_write, csr_mip,      '0,    1'b1, 64'h80);
    // mret into user mode, then an illegal access
    add_step("mpp_user",       csr_write, csr_mstatus,  '0,    1'b1, mstatus_rst | mpie_mpp_m);
    add_step("mret",           csr_mret,  csr_mstatus,  '0,    1'b1, '0, .s_ret(1'b1));
    add_step("user_mscratch",  csr_read,  csr_mscratch, '0,    1'b0, '0,
             .s_trap(1'b1), .s_priv(priv_u));
    add_step("user_mcause",    csr_read,  csr_mcause,   '0,    1'b1, 64'd2);
    // counters free running
    add_step("inhibit_off",    csr_write, csr_mcountinhibit, '0, 1'b1, '0);
    add_step("mcycle_write",   csr_write, csr_mcycle,   64'h1000, 1'b0, '0);
    add_step("mcycle_read0",   csr_read,  csr_mcycle,   '0,    1'b1, 64'h1000);
    add_step("idle_0",         op_nop,    csr_mcycle,   '0,    1'b1, '0);
    add_step("idle_1",         op_nop,    csr_mcycle,   '0,    1'b1, '0);
    add_step("mcycle_read1",   csr_read,  csr_mcycle,   '0,    1'b1, 64'h1003); // 3 edges later
    add_step("minstret_write", csr_write, csr_minstret, 64'h200, 1'b0, '0, .s_instret(1'b1));
    add_step("instret_a",      op_nop,    csr_minstret, '0,    1'b1, '0, .s_instret(1'b1));
    add_step("instret_gap",    op_nop,    csr_minstret, '0,    1'b1, '0);
    add_step("instret_b",      op_nop,    csr_minstret, '0,    1'b1, '0, .s_instret(1'b1));
    add_step("minstret_read",  csr_read,  csr_minstret, '0,    1'b1, 64'h202);
    // both counters inhibited
    add_step("inhibit_on",     csr_write, csr_mcountinhibit, 64'h5, 1'b1, '0);
    add_step("inh_mcycle_wr",  csr_write, csr_mcycle,   64'h3000, 1'b0, '0);
    add_step("inh_instret_wr", csr_write, csr_minstret, 64'h400, 1'b1, 64'h202,
             .s_instret(1'b1));
    add_step("inh_pulse",      op_nop,    csr_minstret, '0,    1'b1, '0, .s_instret(1'b1));
    add_step("inh_mcycle_rd",  csr_read,  csr_mcycle,   '0,    1'b1, 64'h3000);
    add_step("inh_instret_rd", csr_read,  csr_minstret, '0,    1'b1, 64'h400);
    add_step("inhibit_clear",  csr_write, csr_mcountinhibit, '0, 1'b1, 64'h5);
  endtask

  initial
  begin : main_seq
    step_t s;
    int    errs_before;
    void'($urandom(35));
    rst       = 1'b1;
    address   = csr_misa;
    op        = op_nop;
    wdata     = '0;
    globstall = 1'b0;
    pc        = '0;
    instret   = 1'b0;
    exc       = '0;
    err_count  = 0;
    fail_steps = 0;
    build_table();
    table_ready = 1'b1;
    repeat (rst_cycles) @(posedge clk);
    rst <= 1'b0;
    foreach (steps[i])
    begin
      s = steps[i];
      @(posedge clk);
      address   <= s.addr;
      op        <= s.op;
      wdata     <= s.wdata;
      globstall <= s.stall;
      pc        <= s.pc;
      instret   <= s.instret;
      exc       <= s.exc;
      @(negedge clk);                // outputs settled, state not yet updated
      errs_before = err_count;
      if (s.chk_rd)
        check_word(names[i], "rdata", s.exp_rd, rdata);
      // mepc and mtvec also leave on their own ports
      if (s.chk_rd && s.op == csr_read && s.addr == csr_mepc)
        check_word(names[i], "return_address", s.exp_rd, return_address);
      if (s.chk_rd && s.op == csr_read && s.addr == csr_mtvec)
        check_word(names[i], "trap_address", s.exp_rd, trap_address);
      check_bit(names[i], "gototrap", s.exp_trap, gototrap);
      check_bit(names[i], "returnfromtrap", s.exp_ret, returnfromtrap);
      check_priv(names[i], s.exp_priv, privlvl);
      if (err_count == errs_before)
        $display("step %-16s ok", names[i]);
      else
      begin
        $display("step %-16s failed", names[i]);
        fail_steps++;
      end
    end
    $display("steps %0d, failed steps %0d, failed checks %0d",
             steps.size(), fail_steps, err_count);
    if (err_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  // twice the expected run time, plus slack
  initial
  begin : watchdog
    int limit_ns;
    wait (table_ready);
    limit_ns = (steps.size() + rst_cycles) * clk_period * 2 + 100;
    #(limit_ns);
    $display("timeout: the run did not end within %0d ns", limit_ns);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== sim.f ====
verilog/riscv_csr_pkg.sv
verilog/riscv_counter.sv
verilog/riscv_csr_decode.sv
verilog/riscv_csr_trap.sv
verilog/riscv_csr_regs.sv
verilog/riscv_csrfile.sv
test/riscv_csrfile_tb.sv

// ==== Makefile ====
# verilator build and run of the csr file testbench
TOP = riscv_csrfile_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -j 0 -Wno-fatal --top-module $(TOP) -f sim.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir
